// ==== rtcClock.f ====
verilog/rtcPkg.sv
verilog/RtcBusIf.sv
verilog/BcdFieldReg.sv
verilog/RtcRegBank.sv
verilog/RtcBusSequencer.sv
verilog/RtcClockTop.sv
verif/RtcBankChecker.sv
verif/RtcClockTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the RTC front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f rtcClock.f --top-module RtcClockTb -o simRtc
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/simRtc +verilator+error+limit+100)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== verif/RtcBankChecker.sv ====
// Bound assertions on bus phase exclusivity, bus drive, address phase data and done pulse
`timescale 1ns/10ps
module RtcBankChecker
(
	input logic       CLK,
	input logic       RST,
	input logic       addrPhase,
	input logic       readPhase,
	input logic       writePhase,
	input logic       busDrive,
	input logic       done,
	input logic [7:0] address,  // Register under access
	input logic [7:0] busOut
);

	int assertFails = 0; // Failure count for the summary

	phaseExclusive: assert property (@(posedge CLK) disable iff (RST)
		$onehot0({addrPhase, readPhase, writePhase}))
	else
	begin
		$error("More than one bus phase is active");
		assertFails++;
	end

	driveRule: assert property (@(posedge CLK) disable iff (RST)
		busDrive == (addrPhase || writePhase))
	else
	begin
		$error("Bus drive does not follow the address and write phases");
		assertFails++;
	end

	addrOnBus: assert property (@(posedge CLK) disable iff (RST)
		addrPhase |-> busOut == address)
	else
	begin
		$error("Bus does not carry the address in the address phase");
		assertFails++;
	end

	doneIdle: assert property (@(posedge CLK) disable iff (RST)
		$rose(done) |-> !(addrPhase || readPhase || writePhase))
	else
	begin
		$error("Done rose while a bus phase was active");
		assertFails++;
	end

endmodule

// Top level sees both sides of the bus and the done pulse
bind RtcClockTop RtcBankChecker chk
(
	.CLK        (CLK),
	.RST        (RST),
	.addrPhase  (addrPhase),
	.readPhase  (readPhase),
	.writePhase (writePhase),
	.busDrive   (busDrive),
	.done       (done),
	.address    (rtcBus.address),
	.busOut     (busOut)
);

// ==== verif/RtcClockTb.sv ====
// Testbench for the RTC front end with RTC bus model, button edit table, burst checks and summary
`timescale 1ns/10ps
module RtcClockTb;

	typedef struct packed
	{
		logic [6:0] cursor;   // Field address under edit
		logic       dirUp;    // 1 presses up, 0 presses down
		logic [3:0] hold;     // Cycles the button stays pressed
		logic [7:0] expValue; // Field value after the press
	} editRow_t;

	localparam int ROWS     = 20;
	localparam int HOLD_MAX = 6;
	localparam logic [31:0] SEED = 32'h77e6_03e3;
	// Reset, edit rows, one read and two write bursts, slack around each burst, doubled
	localparam int TIMEOUT_CYCLES = 2 * (3 + ROWS * (HOLD_MAX + 4) + 18 + 2 * 24 + 3 * 4);

	localparam editRow_t EDIT_TAB [ROWS] = '{
		'{7'h22, 1'b0, 4'd1, 8'h59}, // Minute 00 down wraps
		'{7'h22, 1'b1, 4'd1, 8'h00}, // Minute 59 up wraps
		'{7'h22, 1'b1, 4'd6, 8'h01}, // Held button, one step
		'{7'h25, 1'b0, 4'd1, 8'h12}, // Month 01 down wraps
		'{7'h25, 1'b1, 4'd1, 8'h01}, // Month 12 up wraps
		'{7'h25, 1'b0, 4'd1, 8'h12},
		'{7'h25, 1'b0, 4'd1, 8'h11},
		'{7'h25, 1'b0, 4'd1, 8'h10},
		'{7'h25, 1'b0, 4'd2, 8'h09}, // Borrow from tens
		'{7'h25, 1'b1, 4'd1, 8'h10}, // Carry into tens
		'{7'h26, 1'b0, 4'd1, 8'h99},
		'{7'h26, 1'b1, 4'd1, 8'h00},
		'{7'h24, 1'b0, 4'd1, 8'h31},
		'{7'h24, 1'b1, 4'd3, 8'h01},
		'{7'h23, 1'b0, 4'd1, 8'h23},
		'{7'h21, 1'b1, 4'd1, 8'h01},
		'{7'h43, 1'b0, 4'd1, 8'h23},
		'{7'h42, 1'b0, 4'd1, 8'h59},
		'{7'h41, 1'b0, 4'd1, 8'h59},
		'{7'h30, 1'b1, 4'd1, 8'h00}  // No field here, nothing moves
	};

	logic       CLK, RST, start, writeMode, up, down, irq, alarmStop;
	logic [6:0] cursor;
	logic [7:0] busIn = 8'h00; // Driven by the RTC model
	logic [7:0] busOut, year, month, day, hour, minute, second;
	logic [7:0] timerHour, timerMinute, timerSecond;
	logic       busDrive, addrPhase, readPhase, writePhase, busy, done;

	int          errors = 0;
	int          cycleCount = 0;
	logic [31:0] rngState;
	logic [7:0]  rtcAddr = 8'h00;   // Address latched by the RTC model
	logic [7:0]  rtcData [256];     // RTC register contents
	logic [7:0]  expField [256];    // Expected field values by address
	logic [7:0]  addrQ [$];         // busOut seen in address phases
	logic [7:0]  dataQ [$];         // busOut seen in write phases

	RtcClockTop uut (.*);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Run stopped at the cycle limit of %0d, a burst never finished",
				TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	////////////////////
	// RTC bus model

	always @(negedge CLK)
	begin
		if (addrPhase)
			rtcAddr <= busOut;                                 // RTC latches the address
		busIn <= readPhase ? rtcData[rtcAddr] : 8'h00;       // Answer in the data phase
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int rangeLow(input logic [7:0] addr);
		return (addr == rtcPkg::ADDR_MONTH || addr == rtcPkg::ADDR_DAY) ? 1 : 0;
	endfunction

	function automatic int rangeHigh(input logic [7:0] addr);
		case (addr)
			rtcPkg::ADDR_YEAR:                    return 99;
			rtcPkg::ADDR_MONTH:                   return 12;
			rtcPkg::ADDR_DAY:                     return 31;
			rtcPkg::ADDR_HOUR, rtcPkg::ADDR_T_HOUR: return 23;
			default:                              return 59; // Minutes and seconds
		endcase
	endfunction

	function automatic logic [7:0] toBcd(input int n);
		return 8'((n / 10) * 16 + n % 10);
	endfunction

	function automatic logic [7:0] fieldAddr(input int i); // i-th field in burst order
		return rtcPkg::accessSeq[rtcPkg::CTRL_COUNT + i];
	endfunction

	function automatic logic isField(input logic [7:0] addr);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < rtcPkg::FIELD_COUNT; i++)
			if (fieldAddr(i) == addr)
				hit = 1'b1;
		return hit;
	endfunction

	function automatic logic [7:0] fieldOut(input logic [7:0] addr);
		case (addr)
			rtcPkg::ADDR_YEAR:     return year;
			rtcPkg::ADDR_MONTH:    return month;
			rtcPkg::ADDR_DAY:      return day;
			rtcPkg::ADDR_HOUR:     return hour;
			rtcPkg::ADDR_MINUTE:   return minute;
			rtcPkg::ADDR_SECOND:   return second;
			rtcPkg::ADDR_T_HOUR:   return timerHour;
			rtcPkg::ADDR_T_MINUTE: return timerMinute;
			default:               return timerSecond;
		endcase
	endfunction

	////////////////////
	// Checks and drivers

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkFields();
		logic [7:0] a;
		for (int i = 0; i < rtcPkg::FIELD_COUNT; i++)
		begin
			a = fieldAddr(i);
			checkValue($sformatf("field %02h", a), fieldOut(a), expField[a]);
		end
	endtask

	task automatic pressButton(input editRow_t row);
		cursor = row.cursor;
		up     = row.dirUp;
		down   = !row.dirUp;
		repeat (row.hold) @(negedge CLK);
		up   = 1'b0;
		down = 1'b0;
		repeat (3) @(negedge CLK); // Sample, step pulse, field update
	endtask

	task automatic runBurst(input logic wr, input logic extraStart);
		int busyCycles;
		int readCycles;
		int accesses;
		int first;
		busyCycles = 0;
		readCycles = 0;
		accesses   = wr ? rtcPkg::SEQ_COUNT : rtcPkg::FIELD_COUNT;
		first      = wr ? 0 : rtcPkg::CTRL_COUNT;
		addrQ.delete();
		dataQ.delete();
		start     = 1'b1;
		writeMode = wr;
		@(negedge CLK);
		start = 1'b0;
		while (!done)
		begin
			if (busy)
				busyCycles++;
			if (readPhase)
				readCycles++;
			if (addrPhase)
				addrQ.push_back(busOut);
			if (writePhase)
				dataQ.push_back(busOut);
			start = extraStart && (busyCycles == 5); // Pulse while busy
			@(negedge CLK);
		end
		start = 1'b0;
		checkValue("busy cycles", busyCycles, 2 * accesses);
		checkValue("read phases", readCycles, wr ? 0 : accesses);
		checkValue("busy", busy, 1'b0);
		checkValue("address phases", addrQ.size(), accesses);
		for (int i = 0; i < addrQ.size() && i < accesses; i++)
			checkValue("busOut", addrQ[i], rtcPkg::accessSeq[first + i]);
		@(negedge CLK);
		checkValue("done", done, 1'b0); // One-cycle pulse
	endtask

	task automatic checkWriteData(input logic [7:0] timerExp, input logic [7:0] initExp);
		logic [7:0] expQ [$];
		expQ.push_back(timerExp);
		expQ.push_back(rtcPkg::CTRL_FLAG_CLEAR);
		expQ.push_back(initExp);
		for (int i = 0; i < rtcPkg::FIELD_COUNT; i++)
			expQ.push_back(expField[fieldAddr(i)]);
		checkValue("write phases", dataQ.size(), expQ.size());
		for (int i = 0; i < dataQ.size() && i < expQ.size(); i++)
			checkValue($sformatf("busOut write %0d", i), dataQ[i], expQ[i]);
	endtask

	////////////////////
	// Test sequence

	initial
	begin
		logic [7:0] a;
		int         span;
		RST = 1'b1;
		start = 1'b0;
		writeMode = 1'b0;
		cursor = 7'h00;
		up = 1'b0;
		down = 1'b0;
		irq = 1'b0;
		alarmStop = 1'b0;
		rngState = SEED;
		for (int i = 0; i < 256; i++)
		begin
			rtcData[i]  = 8'h00;
			expField[i] = 8'h00;
		end
		for (int i = 0; i < rtcPkg::FIELD_COUNT; i++)
		begin
			a        = fieldAddr(i);
			span     = rangeHigh(a) - rangeLow(a) + 1;
			rngState = xorshift(rngState);
			rtcData[a]  = toBcd(rangeLow(a) + int'(rngState % 32'(span))); // Legal BCD only
			expField[a] = toBcd(rangeLow(a));                              // Reset value
		end
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b0;

		checkFields();
		checkValue("busy", busy, 1'b0);
		checkValue("done", done, 1'b0);
		checkValue("busDrive", busDrive, 1'b0);

		for (int r = 0; r < ROWS; r++)
		begin
			pressButton(EDIT_TAB[r]);
			if (isField({1'b0, EDIT_TAB[r].cursor}))
				expField[{1'b0, EDIT_TAB[r].cursor}] = EDIT_TAB[r].expValue;
			checkFields();
		end

		runBurst(1'b0, 1'b0); // Read all fields from the RTC
		for (int i = 0; i < rtcPkg::FIELD_COUNT; i++)
			expField[fieldAddr(i)] = rtcData[fieldAddr(i)];
		checkFields();
		checkValue("write phases in read", dataQ.size(), 0);

		irq       = 1'b1;
		alarmStop = 1'b1; // Alarm silenced, timer goes off
		runBurst(1'b1, 1'b0);
		checkWriteData(rtcPkg::CTRL_TIMER_OFF, rtcPkg::CTRL_INIT_FIRST);

		alarmStop = 1'b0;
		runBurst(1'b1, 1'b1); // Extra start while busy
		checkWriteData(rtcPkg::CTRL_TIMER_ON, rtcPkg::CTRL_INIT_DONE);

		repeat (2) @(negedge CLK);
		$display("Summary: %0d check errors, %0d assertion failures", errors, uut.chk.assertFails);
		if (errors == 0 && uut.chk.assertFails == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== verilog/BcdFieldReg.sv ====
// BCD time field register with wrapping up/down edit and bus load
`timescale 1ns/10ps
module BcdFieldReg
#(
	parameter logic [7:0] minValue = 8'h00, // Lowest legal BCD value
	parameter logic [7:0] maxValue = 8'h59  // Highest legal BCD value
)
(
	input  logic             CLK,
	input  logic             RST,
	input  logic             stepUp,   // One-cycle increment pulse
	input  logic             stepDown, // One-cycle decrement pulse
	input  logic             editSel,  // Cursor points at this field
	input  logic             loadSel,  // Read burst delivers this field
	input  rtcPkg::rtcWord_u loadData,
	output rtcPkg::rtcWord_u value
);

	rtcPkg::rtcWord_u incValue; // Value after one step up
	rtcPkg::rtcWord_u decValue; // Value after one step down

	always_comb
	begin
		incValue = value;
		if (value.raw >= maxValue)
			incValue.raw = minValue; // Wrap at top of range
		else if (value.bcd.units >= 4'd9)
		begin
			incValue.bcd.tens  = value.bcd.tens + 4'd1; // Carry into tens
			incValue.bcd.units = 4'd0;
		end
		else
			incValue.bcd.units = value.bcd.units + 4'd1;
	end

	always_comb
	begin
		decValue = value;
		if (value.raw <= minValue)
			decValue.raw = maxValue; // Wrap at bottom of range
		else if (value.bcd.units == 4'd0)
		begin
			decValue.bcd.tens  = value.bcd.tens - 4'd1; // Borrow from tens
			decValue.bcd.units = 4'd9;
		end
		else
			decValue.bcd.units = value.bcd.units - 4'd1;
	end

	always_ff @(posedge CLK, posedge RST)
	begin
		if (RST)
			value.raw <= minValue;
		else if (loadSel)
			value <= loadData; // Bus load wins over an edit
		else if (editSel && stepUp)
			value <= incValue;
		else if (editSel && stepDown)
			value <= decValue;
	end

endmodule

// ==== verilog/RtcBusIf.sv ====
// Interface for the RTC bus phases, address and data between sequencer and register bank
`timescale 1ns/10ps
interface RtcBusIf;

	logic       addrPhase;  // Address cycle on the multiplexed bus
	logic       readPhase;  // RTC drives data
	logic       writePhase; // Bank drives data
	logic [7:0] address;    // Register under access, held over both cycles
	logic [7:0] busIn;      // Byte from the RTC
	logic [7:0] busOut;     // Byte toward the RTC
	logic       busDrive;   // Output enable of busOut

	modport seq
	(
		output addrPhase, readPhase, writePhase, address
	);

	modport bank
	(
		input  addrPhase, readPhase, writePhase, address, busIn,
		output busOut, busDrive
	);

endinterface

// ==== verilog/RtcBusSequencer.sv ====
// RTC bus sequencer for read and write bursts with address and data phases
`timescale 1ns/10ps
module RtcBusSequencer
(
	input  logic  CLK,
	input  logic  RST,
	RtcBusIf.seq  bus,
	input  logic  start,     // Begins a burst when idle
	input  logic  writeMode, // Sampled with start
	output logic  busy,
	output logic  done       // Pulse after the last data phase
);

	localparam int IDX_W = $clog2(rtcPkg::SEQ_COUNT);

	logic [IDX_W-1:0] seqIdx;     // Position in accessSeq
	logic             dataPhase;  // Second cycle of an access
	logic             writeBurst; // Burst direction
	logic             lastAccess;

	assign lastAccess = (seqIdx == IDX_W'(rtcPkg::SEQ_COUNT - 1));

	always_ff @(posedge CLK, posedge RST)
	begin
		if (RST)
		begin
			busy       <= 1'b0;
			done       <= 1'b0;
			seqIdx     <= '0;
			dataPhase  <= 1'b0;
			writeBurst <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (!busy)
			begin
				if (start)
				begin
					busy       <= 1'b1;
					dataPhase  <= 1'b0;
					writeBurst <= writeMode;
					// Reads skip the control registers
					seqIdx     <= writeMode ? '0 : IDX_W'(rtcPkg::CTRL_COUNT);
				end
			end
			else if (!dataPhase)
				dataPhase <= 1'b1; // Address cycle done
			else
			begin
				dataPhase <= 1'b0;
				if (lastAccess)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				else
					seqIdx <= seqIdx + 1'b1; // Next register
			end
		end
	end

	////////////////////
	// Bus phase outputs

	assign bus.address    = rtcPkg::accessSeq[seqIdx];
	assign bus.addrPhase  = busy & ~dataPhase;
	assign bus.readPhase  = busy & dataPhase & ~writeBurst;
	assign bus.writePhase = busy & dataPhase & writeBurst;

endmodule

// ==== verilog/RtcClockTop.sv ====
// RTC front end top level joining bus sequencer and register bank
`timescale 1ns/10ps
module RtcClockTop
(
	input  logic       CLK,
	input  logic       RST,
	input  logic       start,
	input  logic       writeMode,
	input  logic [6:0] cursor,
	input  logic       up,
	input  logic       down,
	input  logic       irq,
	input  logic       alarmStop,
	input  logic [7:0] busIn,      // RTC side of the multiplexed bus
	output logic [7:0] busOut,
	output logic       busDrive,
	output logic       addrPhase,
	output logic       readPhase,
	output logic       writePhase,
	output logic       busy,
	output logic       done,
	output logic [7:0] year,
	output logic [7:0] month,
	output logic [7:0] day,
	output logic [7:0] hour,
	output logic [7:0] minute,
	output logic [7:0] second,
	output logic [7:0] timerHour,
	output logic [7:0] timerMinute,
	output logic [7:0] timerSecond
);

	RtcBusIf rtcBus ();

	rtcPkg::rtcWord_u yearW, monthW, dayW, hourW, minuteW, secondW; // Union views of fields
	rtcPkg::rtcWord_u tHourW, tMinuteW, tSecondW;

	assign rtcBus.busIn = busIn;

	RtcBusSequencer seq
	(
		.CLK       (CLK),
		.RST       (RST),
		.bus       (rtcBus.seq),
		.start     (start),
		.writeMode (writeMode),
		.busy      (busy),
		.done      (done)
	);

	RtcRegBank bank
	(
		.CLK         (CLK),
		.RST         (RST),
		.bus         (rtcBus.bank),
		.cursor      (cursor),
		.up          (up),
		.down        (down),
		.irq         (irq),
		.alarmStop   (alarmStop),
		.year        (yearW),
		.month       (monthW),
		.day         (dayW),
		.hour        (hourW),
		.minute      (minuteW),
		.second      (secondW),
		.timerHour   (tHourW),
		.timerMinute (tMinuteW),
		.timerSecond (tSecondW)
	);

	////////////////////
	// Plain port view

	assign busOut      = rtcBus.busOut;
	assign busDrive    = rtcBus.busDrive;
	assign addrPhase   = rtcBus.addrPhase;
	assign readPhase   = rtcBus.readPhase;
	assign writePhase  = rtcBus.writePhase;
	assign year        = yearW.raw;
	assign month       = monthW.raw;
	assign day         = dayW.raw;
	assign hour        = hourW.raw;
	assign minute      = minuteW.raw;
	assign second      = secondW.raw;
	assign timerHour   = tHourW.raw;
	assign timerMinute = tMinuteW.raw;
	assign timerSecond = tSecondW.raw;

endmodule

// ==== verilog/RtcRegBank.sv ====
// RTC register bank with button edges, cursor and address decode, nine fields and write data
`timescale 1ns/10ps
module RtcRegBank
(
	input  logic             CLK,
	input  logic             RST,
	RtcBusIf.bank            bus,
	input  logic [6:0]       cursor,    // Field address under edit
	input  logic             up,
	input  logic             down,
	input  logic             irq,       // Timer interrupt from the RTC
	input  logic             alarmStop, // User silenced the alarm
	output rtcPkg::rtcWord_u year,
	output rtcPkg::rtcWord_u month,
	output rtcPkg::rtcWord_u day,
	output rtcPkg::rtcWord_u hour,
	output rtcPkg::rtcWord_u minute,
	output rtcPkg::rtcWord_u second,
	output rtcPkg::rtcWord_u timerHour,
	output rtcPkg::rtcWord_u timerMinute,
	output rtcPkg::rtcWord_u timerSecond
);

	localparam int NF = rtcPkg::FIELD_COUNT;

	// Ranges in burst order: year month day hour min sec, then timer h m s
	localparam logic [7:0] MIN_TAB [NF] = '{8'h00, 8'h01, 8'h01, 8'h00, 8'h00,
		8'h00, 8'h00, 8'h00, 8'h00};
	localparam logic [7:0] MAX_TAB [NF] = '{8'h99, 8'h12, 8'h31, 8'h23, 8'h59,
		8'h59, 8'h23, 8'h59, 8'h59};

	// One-hot field select for an address, bit order follows accessSeq
	function automatic logic [NF-1:0] fieldSelect(input logic [7:0] addr);
		logic [NF-1:0] sel;
		sel = '0;
		for (int i = 0; i < NF; i++)
			if (addr == rtcPkg::accessSeq[rtcPkg::CTRL_COUNT + i])
				sel[i] = 1'b1;
		return sel;
	endfunction

	////////////////////
	// Button edges

	logic [1:0] btnSync; // Bit 0 up, bit 1 down
	logic [1:0] btnDly;  // Previous sample
	logic [1:0] btnStep; // Registered rising edge

	always_ff @(posedge CLK, posedge RST)
	begin
		if (RST)
		begin
			btnSync <= '0;
			btnDly  <= '0;
			btnStep <= '0;
		end
		else
		begin
			btnSync <= {down, up};
			btnDly  <= btnSync;
			btnStep <= btnSync & ~btnDly; // One pulse per press
		end
	end

	////////////////////
	// Field registers

	logic [NF-1:0]    editSel;        // From cursor
	logic [NF-1:0]    loadSel;        // From read phase address
	rtcPkg::rtcWord_u loadByte;       // busIn captured in read phase
	rtcPkg::rtcWord_u fieldVal [NF];

	assign editSel = fieldSelect({1'b0, cursor});

	always_ff @(posedge CLK, posedge RST)
	begin
		if (RST)
			loadSel <= '0;
		else
			loadSel <= bus.readPhase ? fieldSelect(bus.address) : '0;
	end

	always_ff @(posedge CLK)
		loadByte.raw <= bus.busIn;

	for (genvar i = 0; i < NF; i++)
	begin : gField
		BcdFieldReg #(.minValue(MIN_TAB[i]), .maxValue(MAX_TAB[i])) fieldReg
		(
			.CLK      (CLK),
			.RST      (RST),
			.stepUp   (btnStep[0]),
			.stepDown (btnStep[1]),
			.editSel  (editSel[i]),
			.loadSel  (loadSel[i]),
			.loadData (loadByte),
			.value    (fieldVal[i])
		);
	end

	assign year        = fieldVal[0];
	assign month       = fieldVal[1];
	assign day         = fieldVal[2];
	assign hour        = fieldVal[3];
	assign minute      = fieldVal[4];
	assign second      = fieldVal[5];
	assign timerHour   = fieldVal[6];
	assign timerMinute = fieldVal[7];
	assign timerSecond = fieldVal[8];

	////////////////////
	// Write data toward RTC

	logic          initDone;  // Init byte already sent once
	logic [NF-1:0] writeSel;
	logic [7:0]    nextWrite;
	logic [7:0]    writeByte; // Valid during the data phase

	assign writeSel = fieldSelect(bus.address);

	always_comb
	begin
		nextWrite = rtcPkg::CTRL_UNKNOWN;
		case (bus.address)
			rtcPkg::ADDR_CTRL_TIMER:
				nextWrite = (!irq || alarmStop) ? rtcPkg::CTRL_TIMER_OFF : rtcPkg::CTRL_TIMER_ON;
			rtcPkg::ADDR_CTRL_FLAG:
				nextWrite = rtcPkg::CTRL_FLAG_CLEAR;
			rtcPkg::ADDR_CTRL_INIT:
				nextWrite = initDone ? rtcPkg::CTRL_INIT_DONE : rtcPkg::CTRL_INIT_FIRST;
			default:
				for (int i = 0; i < NF; i++)
					if (writeSel[i])
						nextWrite = fieldVal[i].raw; // Time field goes out as is
		endcase
	end

	always_ff @(posedge CLK)
		writeByte <= nextWrite;

	always_ff @(posedge CLK, posedge RST)
	begin
		if (RST)
			initDone <= 1'b0;
		else if (bus.writePhase && bus.address == rtcPkg::ADDR_CTRL_INIT)
			initDone <= 1'b1; // Sticky until reset, seen once the init write phase falls
	end

	// Address phase puts the address itself on the bus
	assign bus.busOut   = bus.addrPhase ? bus.address : writeByte;
	assign bus.busDrive = bus.addrPhase | bus.writePhase;

endmodule

// ==== verilog/rtcPkg.sv ====
// RTC register addresses, control bytes, BCD field word union and burst access order
package rtcPkg;

	////////////////////
	// Field word

	typedef struct packed
	{
		logic [3:0] tens;  // Upper BCD digit
		logic [3:0] units; // Lower BCD digit
	} bcdDigits_t;

	typedef union packed
	{
		logic [7:0] raw;  // Byte as it travels on the RTC bus
		bcdDigits_t bcd;  // Same byte split into digits for editing
	} rtcWord_u;

	////////////////////
	// RTC register map

	localparam logic [7:0] ADDR_CTRL_TIMER = 8'h00; // Timer enable control
	localparam logic [7:0] ADDR_CTRL_FLAG  = 8'h01; // Interrupt flag control
	localparam logic [7:0] ADDR_CTRL_INIT  = 8'h02; // One-time init control
	localparam logic [7:0] ADDR_SECOND     = 8'h21;
	localparam logic [7:0] ADDR_MINUTE     = 8'h22;
	localparam logic [7:0] ADDR_HOUR       = 8'h23;
	localparam logic [7:0] ADDR_DAY        = 8'h24;
	localparam logic [7:0] ADDR_MONTH      = 8'h25;
	localparam logic [7:0] ADDR_YEAR       = 8'h26;
	localparam logic [7:0] ADDR_T_SECOND   = 8'h41; // Countdown timer fields
	localparam logic [7:0] ADDR_T_MINUTE   = 8'h42;
	localparam logic [7:0] ADDR_T_HOUR     = 8'h43;

	// Bytes written to the control registers
	localparam logic [7:0] CTRL_TIMER_OFF  = 8'h00;
	localparam logic [7:0] CTRL_TIMER_ON   = 8'h08;
	localparam logic [7:0] CTRL_FLAG_CLEAR = 8'h04;
	localparam logic [7:0] CTRL_INIT_FIRST = 8'h10; // Sent until the first write burst ends
	localparam logic [7:0] CTRL_INIT_DONE  = 8'h00;
	localparam logic [7:0] CTRL_UNKNOWN    = 8'hFF; // Address outside the map

	////////////////////
	// Burst order

	localparam int FIELD_COUNT = 9;
	localparam int CTRL_COUNT  = 3;
	localparam int SEQ_COUNT   = CTRL_COUNT + FIELD_COUNT;

	// Control bytes first, a read burst skips them
	localparam logic [7:0] accessSeq [SEQ_COUNT] = '{
		ADDR_CTRL_TIMER, ADDR_CTRL_FLAG, ADDR_CTRL_INIT,
		ADDR_YEAR, ADDR_MONTH, ADDR_DAY,
		ADDR_HOUR, ADDR_MINUTE, ADDR_SECOND,
		ADDR_T_HOUR, ADDR_T_MINUTE, ADDR_T_SECOND
	};

endpackage
